// File: source/ex_pkg.sv
package ex_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data path width
  localparam int XLEN = 32;

  // One data word
  typedef logic [XLEN-1:0] word_t;

  // Register file address, 64 entries
  typedef logic [5:0] reg_addr_t;

  ////////////////////
  // Operators
  ////////////////////

  // ALU operators, all 16 codes used
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    // Branch compares
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_H   = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HU  = 2'd3
  } mult_op_e;

  ////////////////////
  // Request and write port bundles
  ////////////////////

  // ALU request from decode
  typedef struct packed {
    logic    en;
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   c;
  } alu_req_t;

  // Multiplier request from decode
  typedef struct packed {
    logic     en;
    mult_op_e op;
    word_t    a;
    word_t    b;
  } mult_req_t;

  // One register file write port
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } rf_wr_t;

endpackage

// File: source/ex_alu.sv
`timescale 1ns/10ps

module ex_alu (
  input  ex_pkg::alu_req_t alu_req_i,
  output ex_pkg::word_t    result_o,
  output logic             cmp_result_o,
  output ex_pkg::word_t    jump_target_o,
  output logic             branch_decision_o
);
  import ex_pkg::*;

  logic          sub_en;
  logic          signed_cmp;
  logic [XLEN:0] add_a;
  logic [XLEN:0] add_b;
  logic [XLEN:0] add_result;
  logic          is_equal;
  logic          is_less;
  logic          shift_left;
  logic          shift_arith;
  logic [4:0]    shift_amt;
  word_t         shift_src;
  logic [XLEN:0] shift_ext;
  logic [XLEN:0] shift_full;
  word_t         shift_result;

  ////////////////////
  // Adder and compare
  ////////////////////

  // Everything except ADD goes through the subtractor
  assign sub_en     = (alu_req_i.op != ALU_ADD);
  assign signed_cmp = (alu_req_i.op == ALU_SLT) || (alu_req_i.op == ALU_LT) ||
                      (alu_req_i.op == ALU_GE);

  // One extra bit so the sign of a-b is never lost
  assign add_a      = {signed_cmp & alu_req_i.a[XLEN-1], alu_req_i.a};
  assign add_b      = {signed_cmp & alu_req_i.b[XLEN-1], alu_req_i.b} ^ {(XLEN+1){sub_en}};
  assign add_result = add_a + add_b + {{XLEN{1'b0}}, sub_en};

  assign is_equal = (alu_req_i.a == alu_req_i.b);
  assign is_less  = add_result[XLEN];

  always_comb begin
    unique case (alu_req_i.op)
      ALU_EQ:                             cmp_result_o = is_equal;
      ALU_NE:                             cmp_result_o = ~is_equal;
      ALU_SLT, ALU_SLTU, ALU_LT, ALU_LTU: cmp_result_o = is_less;
      ALU_GE, ALU_GEU:                    cmp_result_o = ~is_less;
      default:                            cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////
  // Shifter
  ////////////////////

  assign shift_left  = (alu_req_i.op == ALU_SLL);
  assign shift_arith = (alu_req_i.op == ALU_SRA);
  assign shift_amt   = alu_req_i.b[4:0];

  // Left shift is a right shift of the bit-reversed operand
  always_comb begin
    if (shift_left) begin
      shift_src = {<<{alu_req_i.a}};
    end else begin
      shift_src = alu_req_i.a;
    end
  end

  // Fill bit is the sign only for SRA
  assign shift_ext  = {shift_arith & alu_req_i.a[XLEN-1], shift_src};
  assign shift_full = $signed(shift_ext) >>> shift_amt;

  always_comb begin
    if (shift_left) begin
      shift_result = {<<{shift_full[XLEN-1:0]}};
    end else begin
      shift_result = shift_full[XLEN-1:0];
    end
  end

  ////////////////////
  // Result mux
  ////////////////////

  always_comb begin
    unique case (alu_req_i.op)
      ALU_ADD, ALU_SUB:          result_o = add_result[XLEN-1:0];
      ALU_AND:                   result_o = alu_req_i.a & alu_req_i.b;
      ALU_OR:                    result_o = alu_req_i.a | alu_req_i.b;
      ALU_XOR:                   result_o = alu_req_i.a ^ alu_req_i.b;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      // Compares return 0 or 1
      default:                   result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

  // Branch outputs to fetch
  assign branch_decision_o = cmp_result_o;
  assign jump_target_o     = alu_req_i.c;

endmodule

// File: source/ex_mult.sv
`timescale 1ns/10ps

module ex_mult #(
  parameter int MULH_LATENCY = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::mult_req_t mult_req_i,
  input  logic              ex_ready_i,
  output ex_pkg::word_t     result_o,
  output logic              ready_o,
  output logic              multicycle_o
);
  import ex_pkg::*;

  // Counter holds up to MULH_LATENCY-2
  localparam int CNT_W = $clog2(MULH_LATENCY);

  logic                     high_op;
  logic                     start;
  logic                     sign_a;
  logic                     sign_b;
  logic signed [XLEN:0]     op_a_ext;
  logic signed [XLEN:0]     op_b_ext;
  logic signed [2*XLEN+1:0] prod_full;
  logic [2*XLEN-1:0]        prod_q;
  word_t                    prod_lo;
  logic                     busy_q;
  logic [CNT_W-1:0]         cnt_q;

  ////////////////////
  // Low product
  ////////////////////

  // Low word is the same for every signedness
  assign prod_lo = mult_req_i.a * mult_req_i.b;

  ////////////////////
  // High product
  ////////////////////

  assign high_op = mult_req_i.en && (mult_req_i.op != MUL_LO);
  assign start   = high_op && !busy_q;

  // MULH signs both, MULHSU only a, MULHU neither
  assign sign_a = (mult_req_i.op == MUL_H) || (mult_req_i.op == MUL_HSU);
  assign sign_b = (mult_req_i.op == MUL_H);

  assign op_a_ext  = {sign_a & mult_req_i.a[XLEN-1], mult_req_i.a};
  assign op_b_ext  = {sign_b & mult_req_i.b[XLEN-1], mult_req_i.b};
  assign prod_full = op_a_ext * op_b_ext;

  // Captured once at start, held while busy
  always_ff @(posedge clk) begin
    if (start) begin
      prod_q <= prod_full[2*XLEN-1:0];
    end
  end

  ////////////////////
  // Latency counter
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      cnt_q  <= CNT_W'(MULH_LATENCY - 2);
    end else if (busy_q) begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else if (ex_ready_i) begin
        // Result consumed, back to idle
        busy_q <= 1'b0;
      end
    end
  end

  // Low while a high-part op is in flight, high once the count is done
  assign ready_o      = busy_q ? (cnt_q == '0) : !high_op;
  assign multicycle_o = busy_q;

  assign result_o = (mult_req_i.op == MUL_LO) ? prod_lo : prod_q[2*XLEN-1:XLEN];

endmodule

// File: source/ex_wb_ctrl.sv
`timescale 1ns/10ps

module ex_wb_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     mult_result_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              mult_ready_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  logic              regfile_we_i,
  input  logic              wb_ready_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  output ex_pkg::rf_wr_t    fw_o,
  output ex_pkg::rf_wr_t    wb_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);
  import ex_pkg::*;

  logic      load_we;
  logic      lsu_we_q;
  reg_addr_t lsu_waddr_q;

  ////////////////////
  // Forwarding port
  ////////////////////

  // Later assignments win, so CSR beats mult beats ALU
  always_comb begin
    fw_o.we    = regfile_alu_we_i;
    fw_o.waddr = regfile_alu_waddr_i;
    fw_o.wdata = '0;
    if (alu_en_i) begin
      fw_o.wdata = alu_result_i;
    end
    if (mult_en_i) begin
      fw_o.wdata = mult_result_i;
    end
    if (csr_access_i) begin
      fw_o.wdata = csr_rdata_i;
    end
  end

  ////////////////////
  // EX/WB register
  ////////////////////

  // Faulting loads never reach the register file
  assign load_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      lsu_we_q <= load_we;
    end else if (wb_ready_i) begin
      // WB drained and nothing new, drop the write
      lsu_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && load_we) begin
      lsu_waddr_q <= regfile_waddr_i;
    end
  end

  // Load data arrives straight from the LSU in WB
  assign wb_o.we    = lsu_we_q;
  assign wb_o.waddr = lsu_waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

  ////////////////////
  // Stall logic
  ////////////////////

  // Branches resolve here and may leave without WB
  assign ex_ready_o = (mult_ready_i & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;

  // Valid does not look at ex_ready_o
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) &
                      (mult_ready_i & lsu_ready_ex_i & wb_ready_i);

endmodule

// File: source/ex_stage.sv
`timescale 1ns/10ps

module ex_stage #(
  parameter int MULH_LATENCY = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  // Requests from decode
  input  ex_pkg::alu_req_t  alu_req_i,
  input  ex_pkg::mult_req_t mult_req_i,
  // CSR and LSU side
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  // Decode strobes
  input  logic              branch_in_ex_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_alu_we_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              wb_ready_i,
  // Write ports
  output ex_pkg::rf_wr_t    fw_o,
  output ex_pkg::rf_wr_t    wb_o,
  // To fetch
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,
  // Stall control
  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);
  import ex_pkg::*;

  word_t alu_result;
  word_t mult_result;
  logic  mult_ready;

  ////////////////////
  // ALU
  ////////////////////

  // Compare bit reaches fetch through branch_decision_o
  ex_alu u_alu (
    .alu_req_i         (alu_req_i),
    .result_o          (alu_result),
    .cmp_result_o      (),
    .jump_target_o     (jump_target_o),
    .branch_decision_o (branch_decision_o)
  );

  ////////////////////
  // Multiplier
  ////////////////////

  ex_mult #(
    .MULH_LATENCY (MULH_LATENCY)
  ) u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////
  // Write ports and stalls
  ////////////////////

  ex_wb_ctrl u_wb_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .alu_en_i            (alu_req_i.en),
    .mult_en_i           (mult_req_i.en),
    .mult_ready_i        (mult_ready),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .lsu_err_i           (lsu_err_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_we_i        (regfile_we_i),
    .wb_ready_i          (wb_ready_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .fw_o                (fw_o),
    .wb_o                (wb_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

// File: sim/tb_ex_checks.svh
`ifndef TB_EX_CHECKS_SVH
`define TB_EX_CHECKS_SVH

// Tallies for the closing summary line
int value_errs   = 0;
int timeout_errs = 0;

////////////////////
// Compare tasks
////////////////////

// Whole write port, all three fields together
task automatic check_wr(input string name, input ex_pkg::rf_wr_t exp,
                        input ex_pkg::rf_wr_t act);
  if (act !== exp) begin
    value_errs++;
    $display("FAIL %s: expected we=%0b waddr=%0d wdata=%h, actual we=%0b waddr=%0d wdata=%h",
             name, exp.we, exp.waddr, exp.wdata, act.we, act.waddr, act.wdata);
  end
endtask

// Plain data word such as the jump target
task automatic check_word(input string name, input ex_pkg::word_t exp,
                          input ex_pkg::word_t act);
  if (act !== exp) begin
    value_errs++;
    $display("FAIL %s: expected %h, actual %h", name, exp, act);
  end
endtask

// Single level, branch decision or a stall signal
task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    value_errs++;
    $display("FAIL %s: expected %0b, actual %0b", name, exp, act);
  end
endtask

`endif

// File: sim/tb_ex_stage.sv
`timescale 1ns/10ps

module tb_ex_stage;
  import ex_pkg::*;

  localparam int CLK_PERIOD     = 20;
  localparam int MULH_LATENCY   = 3;
  // Cycles any single wait may take
  localparam int TIMEOUT_CYCLES = 20;

  // One table row, stimulus plus expected results
  typedef struct packed {
    alu_req_t  alu;
    mult_req_t mult;
    logic      csr_access;
    word_t     csr_rdata;
    logic      lsu_en;
    word_t     lsu_rdata;
    logic      lsu_err;
    logic      lsu_ready;
    logic      wb_ready;
    logic      branch_in_ex;
    logic      alu_we;
    reg_addr_t alu_waddr;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      stall;
    logic      chk_wb;
    rf_wr_t    exp_fw;
    logic      exp_br;
  } stim_t;

  logic   clk;
  logic   rst_n;
  stim_t  cur;
  rf_wr_t fw;
  rf_wr_t wb;
  word_t  jump_target;
  logic   branch_decision;
  logic   multicycle;
  logic   ex_ready;
  logic   ex_valid;

  stim_t  cases[$];
  string  names[$];
  int     seed;

  `include "tb_ex_checks.svh"

  ex_stage #(
    .MULH_LATENCY (MULH_LATENCY)
  ) dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (cur.alu),
    .mult_req_i          (cur.mult),
    .csr_access_i        (cur.csr_access),
    .csr_rdata_i         (cur.csr_rdata),
    .lsu_en_i            (cur.lsu_en),
    .lsu_rdata_i         (cur.lsu_rdata),
    .lsu_ready_ex_i      (cur.lsu_ready),
    .lsu_err_i           (cur.lsu_err),
    .branch_in_ex_i      (cur.branch_in_ex),
    .regfile_alu_waddr_i (cur.alu_waddr),
    .regfile_alu_we_i    (cur.alu_we),
    .regfile_we_i        (cur.rf_we),
    .regfile_waddr_i     (cur.rf_waddr),
    .wb_ready_i          (cur.wb_ready),
    .fw_o                (fw),
    .wb_o                (wb),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .mult_multicycle_o   (multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Reference rules
  ////////////////////

  // Compare bit, SLT and SLTU share it with the branches
  function automatic logic branch_expect(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_EQ:          return a == b;
      ALU_NE:          return a != b;
      ALU_SLT, ALU_LT: return $signed(a) < $signed(b);
      ALU_GE:          return $signed(a) >= $signed(b);
      ALU_SLTU,
      ALU_LTU:         return a < b;
      ALU_GEU:         return a >= b;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_expect(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return $signed(a) >>> b[4:0];
      default: return {31'b0, branch_expect(op, a, b)};
    endcase
  endfunction

  // 64-bit wrap gives the right high word for every signedness
  function automatic word_t mult_expect(input mult_op_e op, input word_t a, input word_t b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = {{32{a[31] & (op == MUL_H || op == MUL_HSU)}}, a};
    eb = {{32{b[31] & (op == MUL_H)}}, b};
    p  = ea * eb;
    return (op == MUL_LO) ? p[31:0] : p[63:32];
  endfunction

  ////////////////////
  // Table building
  ////////////////////

  // Idle row, no request and no back-pressure
  function automatic stim_t base_stim();
    stim_t s;
    s           = '0;
    s.lsu_ready = 1'b1;
    s.wb_ready  = 1'b1;
    s.alu_we    = 1'b1;
    s.alu_waddr = reg_addr_t'(cases.size() + 1);
    return s;
  endfunction

  // Fill in expected values, then append the row
  task automatic push_case(input string name, input stim_t s);
    word_t d;
    d = '0;
    if (s.alu.en) d = alu_expect(s.alu.op, s.alu.a, s.alu.b);
    if (s.mult.en) d = mult_expect(s.mult.op, s.mult.a, s.mult.b);
    if (s.csr_access) d = s.csr_rdata;
    s.exp_fw = '{we: s.alu_we, waddr: s.alu_waddr, wdata: d};
    s.exp_br = branch_expect(s.alu.op, s.alu.a, s.alu.b);
    names.push_back(name);
    cases.push_back(s);
  endtask

  task automatic alu_case(input string name, input alu_op_e op, input word_t a,
                          input word_t b, input word_t c);
    stim_t s;
    s     = base_stim();
    s.alu = '{en: 1'b1, op: op, a: a, b: b, c: c};
    push_case(name, s);
  endtask

  task automatic mult_case(input string name, input mult_op_e op, input word_t a,
                           input word_t b);
    stim_t s;
    s      = base_stim();
    s.mult = '{en: 1'b1, op: op, a: a, b: b};
    push_case(name, s);
  endtask

  // ALU and MUL_LO both active, CSR must still win
  // Write enable low here, the port we follows the strobe only
  task automatic csr_case(input string name, input word_t data);
    stim_t s;
    s            = base_stim();
    s.alu        = '{en: 1'b1, op: ALU_ADD, a: 32'h11, b: 32'h22, c: 32'h0};
    s.mult       = '{en: 1'b1, op: MUL_LO, a: 32'h3, b: 32'h5};
    s.csr_access = 1'b1;
    s.csr_rdata  = data;
    s.alu_we     = 1'b0;
    push_case(name, s);
  endtask

  task automatic load_case(input string name, input reg_addr_t addr, input word_t data,
                           input logic err);
    stim_t s;
    s           = base_stim();
    s.alu_we    = 1'b0;
    s.lsu_en    = 1'b1;
    s.rf_we     = 1'b1;
    s.rf_waddr  = addr;
    s.lsu_rdata = data;
    s.lsu_err   = err;
    s.chk_wb    = 1'b1;
    push_case(name, s);
  endtask

  task automatic stall_case(input string name, input logic wb_rdy, input logic lsu_rdy,
                            input logic branch);
    stim_t s;
    s              = base_stim();
    s.alu          = '{en: 1'b1, op: ALU_ADD, a: 32'h5, b: 32'h6, c: 32'h0};
    s.wb_ready     = wb_rdy;
    s.lsu_ready    = lsu_rdy;
    s.branch_in_ex = branch;
    s.stall        = 1'b1;
    push_case(name, s);
  endtask

  task automatic build_table();
    // Fixed ALU rows
    alu_case("add",  ALU_ADD,  32'h7fff_ffff, 32'h0000_0001, 32'h0);
    alu_case("sub",  ALU_SUB,  32'h0000_0005, 32'h0000_0007, 32'h0);
    alu_case("and",  ALU_AND,  32'hf0f0_1234, 32'h0ff0_ff00, 32'h0);
    alu_case("or",   ALU_OR,   32'hf000_0001, 32'h0f00_0010, 32'h0);
    alu_case("xor",  ALU_XOR,  32'haaaa_5555, 32'hffff_0000, 32'h0);
    alu_case("sll",  ALU_SLL,  32'h8000_0001, 32'h0000_0004, 32'h0);
    alu_case("srl",  ALU_SRL,  32'h8000_0000, 32'h0000_001f, 32'h0);
    alu_case("sra",  ALU_SRA,  32'h8000_0000, 32'h0000_001f, 32'h0);
    alu_case("slt",  ALU_SLT,  32'hffff_ffff, 32'h0000_0001, 32'h0);
    alu_case("sltu", ALU_SLTU, 32'hffff_ffff, 32'h0000_0001, 32'h0);
    // Branch compares, c carries the target
    alu_case("beq",  ALU_EQ,   32'h0000_1234, 32'h0000_1234, 32'h0000_1000);
    alu_case("bne",  ALU_NE,   32'h0000_1234, 32'h0000_1234, 32'h0000_2000);
    alu_case("blt",  ALU_LT,   32'h8000_0000, 32'h0000_0001, 32'h0000_3000);
    alu_case("bge",  ALU_GE,   32'h8000_0000, 32'h0000_0001, 32'h0000_4000);
    alu_case("bltu", ALU_LTU,  32'h8000_0000, 32'h0000_0001, 32'h0000_5000);
    alu_case("bgeu", ALU_GEU,  32'h8000_0000, 32'h0000_0001, 32'h0000_6000);
    // Every operator once more on random operands
    for (int k = 0; k < 16; k++) begin
      alu_case($sformatf("rand_alu_%0d", k), alu_op_e'(k[3:0]), $random(seed),
               $random(seed), $random(seed));
    end
    // Multiplier, signedness corners first
    mult_case("mul",    MUL_LO,  32'hffff_fffe, 32'h0000_0003);
    mult_case("mulh",   MUL_H,   32'h8000_0000, 32'h8000_0000);
    mult_case("mulhsu", MUL_HSU, 32'hffff_ffff, 32'hffff_ffff);
    mult_case("mulhu",  MUL_HU,  32'hffff_ffff, 32'hffff_ffff);
    for (int k = 0; k < 8; k++) begin
      mult_case($sformatf("rand_mult_%0d", k), mult_op_e'(k[1:0]), $random(seed),
                $random(seed));
    end
    csr_case("csr_priority", 32'hcafe_0001);
    // Good load then a faulting one
    load_case("load",     6'd17, 32'hdead_beef, 1'b0);
    load_case("load_err", 6'd18, 32'h0bad_0bad, 1'b1);
    // Back-pressure rows
    stall_case("wb_stall",        1'b0, 1'b1, 1'b0);
    stall_case("wb_stall_branch", 1'b0, 1'b1, 1'b1);
    stall_case("lsu_stall",       1'b1, 1'b0, 1'b0);
  endtask

  // Called at a falling edge, returns at the falling edge where valid is seen
  task automatic wait_valid(input string name);
    int waited;
    waited = 0;
    while (ex_valid !== 1'b1 && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (ex_valid !== 1'b1) begin
      timeout_errs++;
      $display("%s: ex_valid_o never went high within %0d cycles", name, TIMEOUT_CYCLES);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    stim_t  s;
    string  n;
    logic   high;
    rf_wr_t exp_wb;
    seed  = 66;
    rst_n <= 1'b0;
    cur   <= base_stim();
    build_table();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("reset wb we", 1'b0, wb.we);
    check_bit("reset multicycle", 1'b0, multicycle);

    for (int i = 0; i < cases.size(); i++) begin
      s = cases[i];
      n = names[i];
      @(posedge clk);
      cur <= s;
      @(negedge clk);
      if (s.stall) begin
        // No result may leave while WB or LSU hold back
        check_bit({n, " valid"}, 1'b0, ex_valid);
        check_bit({n, " ready"}, s.branch_in_ex, ex_ready);
      end else begin
        high = s.mult.en && (s.mult.op != MUL_LO);
        // High product is never ready in its first cycle
        if (high) check_bit({n, " first cycle valid"}, 1'b0, ex_valid);
        wait_valid(n);
        check_bit({n, " ready"}, 1'b1, ex_ready);
        // Counter still running when the high result is handed over
        check_bit({n, " multicycle"}, high, multicycle);
      end
      if (s.alu.en || s.mult.en || s.csr_access) begin
        check_wr({n, " fw"}, s.exp_fw, fw);
      end
      check_bit({n, " branch"}, s.exp_br, branch_decision);
      check_word({n, " target"}, s.alu.c, jump_target);
      if (s.chk_wb) begin
        // Load port shows up one clock after valid
        @(negedge clk);
        if (s.lsu_err) begin
          check_bit({n, " wb we"}, 1'b0, wb.we);
        end else begin
          exp_wb = '{we: 1'b1, waddr: s.rf_waddr, wdata: s.lsu_rdata};
          check_wr({n, " wb"}, exp_wb, wb);
        end
      end
    end

    $display("Summary: %0d value errors, %0d timeouts", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+sim
source/ex_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_wb_ctrl.sv
source/ex_stage.sv
sim/tb_ex_stage.sv

// File: Makefile
TOP := tb_ex_stage

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f --Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
